// File: rtl/arduboy_io_pkg.sv
// Arduboy I/O register map, bus widths and shared enum types
package arduboy_io_pkg;
	parameter int data_w = 8; // Bus and register width
	parameter int addr_w = 8; // Low I/O space only
	parameter int prescale_w = 10; // Enough for /1024

	// Port B..F, same PIN/DDR/PORT layout as the AVR part
	parameter logic [addr_w-1:0] pinb_addr = 8'h23;
	parameter logic [addr_w-1:0] ddrb_addr = 8'h24;
	parameter logic [addr_w-1:0] portb_addr = 8'h25;
	parameter logic [addr_w-1:0] pinc_addr = 8'h26;
	parameter logic [addr_w-1:0] ddrc_addr = 8'h27;
	parameter logic [addr_w-1:0] portc_addr = 8'h28;
	parameter logic [addr_w-1:0] pind_addr = 8'h29;
	parameter logic [addr_w-1:0] ddrd_addr = 8'h2a;
	parameter logic [addr_w-1:0] portd_addr = 8'h2b;
	parameter logic [addr_w-1:0] pine_addr = 8'h2c;
	parameter logic [addr_w-1:0] ddre_addr = 8'h2d;
	parameter logic [addr_w-1:0] porte_addr = 8'h2e;
	parameter logic [addr_w-1:0] pinf_addr = 8'h2f;
	parameter logic [addr_w-1:0] ddrf_addr = 8'h30;
	parameter logic [addr_w-1:0] portf_addr = 8'h31;

	// Timer 0 block
	parameter logic [addr_w-1:0] tifr0_addr = 8'h35;
	parameter logic [addr_w-1:0] tccr0a_addr = 8'h44;
	parameter logic [addr_w-1:0] tccr0b_addr = 8'h45;
	parameter logic [addr_w-1:0] tcnt0_addr = 8'h46;
	parameter logic [addr_w-1:0] ocr0a_addr = 8'h47;
	parameter logic [addr_w-1:0] ocr0b_addr = 8'h48;
	parameter logic [addr_w-1:0] timsk0_addr = 8'h6e;

	parameter int tov_bit = 0; // Same positions in TIFR0 and TIMSK0
	parameter int ocfa_bit = 1;
	parameter int ocfb_bit = 2;

	typedef enum logic [4:0] {
		reg_none,
		reg_pinb, reg_ddrb, reg_portb, reg_pinc, reg_ddrc, reg_portc,
		reg_pind, reg_ddrd, reg_portd, reg_pine, reg_ddre, reg_porte,
		reg_pinf, reg_ddrf, reg_portf,
		reg_tifr0, reg_tccr0a, reg_tccr0b, reg_tcnt0, reg_ocr0a, reg_ocr0b, reg_timsk0
	} reg_sel_e;

	typedef enum logic [1:0] {apb_idle, apb_setup, apb_access} apb_state_e;

	// Timer write select, the timer rows of reg_sel_e
	typedef enum logic [2:0] {
		tim_tccr0a, tim_tccr0b, tim_tcnt0, tim_ocr0a, tim_ocr0b, tim_timsk0, tim_tifr0
	} tim_reg_e;

	typedef enum logic [2:0] {
		cs_stop = 3'd0, cs_div1 = 3'd1, cs_div8 = 3'd2,
		cs_div64 = 3'd3, cs_div256 = 3'd4, cs_div1024 = 3'd5
	} clk_sel_e; // 6 and 7 unused, treated as stopped

	typedef enum logic [1:0] {wgm_normal = 2'b00, wgm_fast_pwm = 2'b11} wgm_e;
endpackage

// File: rtl/apb_io_ctrl.sv
// APB slave for the I/O space with phase FSM, address decode, write strobes and read mux
`timescale 1ns/10ps
module apb_io_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [arduboy_io_pkg::addr_w-1:0] paddr,
	input  logic [arduboy_io_pkg::data_w-1:0] pwdata,
	output logic [arduboy_io_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [4:0] port_wr, // One-hot, bit 0 is port B
	output logic [4:0] ddr_wr,
	output logic tim_wr,
	output arduboy_io_pkg::tim_reg_e tim_reg,
	output logic [arduboy_io_pkg::data_w-1:0] wdata,
	input  logic [arduboy_io_pkg::data_w-1:0] port_q_b, port_q_c, port_q_d, port_q_e, port_q_f,
	input  logic [arduboy_io_pkg::data_w-1:0] ddr_q_b, ddr_q_c, ddr_q_d, ddr_q_e, ddr_q_f,
	input  logic [arduboy_io_pkg::data_w-1:0] pin_q_b, pin_q_c, pin_q_d, pin_q_e, pin_q_f,
	input  logic [arduboy_io_pkg::data_w-1:0] tccr0a_q, tccr0b_q, tcnt0_q, ocr0a_q,
	input  logic [arduboy_io_pkg::data_w-1:0] ocr0b_q, timsk0_q, tifr0_q
);
	arduboy_io_pkg::apb_state_e state; // Phase seen at the last edge
	arduboy_io_pkg::reg_sel_e sel;
	logic access;
	logic is_pin;
	logic is_tim;
	logic wr_en;
	logic [arduboy_io_pkg::data_w-1:0] rd_mux;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= arduboy_io_pkg::apb_idle;
		else
		begin
			case (state)
				arduboy_io_pkg::apb_setup:
					if (psel && penable)
						state <= arduboy_io_pkg::apb_access;
					else if (!psel)
						state <= arduboy_io_pkg::apb_idle;
				default: // Idle or just finished a transfer
					if (psel && !penable)
						state <= arduboy_io_pkg::apb_setup;
					else
						state <= arduboy_io_pkg::apb_idle;
			endcase
		end
	end

	// Access cycle follows a registered setup, no wait states
	assign access = (state == arduboy_io_pkg::apb_setup) && psel && penable;

	always_comb
	begin
		case (paddr)
			arduboy_io_pkg::pinb_addr: sel = arduboy_io_pkg::reg_pinb;
			arduboy_io_pkg::ddrb_addr: sel = arduboy_io_pkg::reg_ddrb;
			arduboy_io_pkg::portb_addr: sel = arduboy_io_pkg::reg_portb;
			arduboy_io_pkg::pinc_addr: sel = arduboy_io_pkg::reg_pinc;
			arduboy_io_pkg::ddrc_addr: sel = arduboy_io_pkg::reg_ddrc;
			arduboy_io_pkg::portc_addr: sel = arduboy_io_pkg::reg_portc;
			arduboy_io_pkg::pind_addr: sel = arduboy_io_pkg::reg_pind;
			arduboy_io_pkg::ddrd_addr: sel = arduboy_io_pkg::reg_ddrd;
			arduboy_io_pkg::portd_addr: sel = arduboy_io_pkg::reg_portd;
			arduboy_io_pkg::pine_addr: sel = arduboy_io_pkg::reg_pine;
			arduboy_io_pkg::ddre_addr: sel = arduboy_io_pkg::reg_ddre;
			arduboy_io_pkg::porte_addr: sel = arduboy_io_pkg::reg_porte;
			arduboy_io_pkg::pinf_addr: sel = arduboy_io_pkg::reg_pinf;
			arduboy_io_pkg::ddrf_addr: sel = arduboy_io_pkg::reg_ddrf;
			arduboy_io_pkg::portf_addr: sel = arduboy_io_pkg::reg_portf;
			arduboy_io_pkg::tifr0_addr: sel = arduboy_io_pkg::reg_tifr0;
			arduboy_io_pkg::tccr0a_addr: sel = arduboy_io_pkg::reg_tccr0a;
			arduboy_io_pkg::tccr0b_addr: sel = arduboy_io_pkg::reg_tccr0b;
			arduboy_io_pkg::tcnt0_addr: sel = arduboy_io_pkg::reg_tcnt0;
			arduboy_io_pkg::ocr0a_addr: sel = arduboy_io_pkg::reg_ocr0a;
			arduboy_io_pkg::ocr0b_addr: sel = arduboy_io_pkg::reg_ocr0b;
			arduboy_io_pkg::timsk0_addr: sel = arduboy_io_pkg::reg_timsk0;
			default: sel = arduboy_io_pkg::reg_none; // Hole in the map
		endcase
	end

	assign is_pin = sel inside {arduboy_io_pkg::reg_pinb, arduboy_io_pkg::reg_pinc,
		arduboy_io_pkg::reg_pind, arduboy_io_pkg::reg_pine, arduboy_io_pkg::reg_pinf};

	// Timer rows of the map narrowed to the timer's own select
	always_comb
	begin
		is_tim = 1'b1;
		case (sel)
			arduboy_io_pkg::reg_tccr0a: tim_reg = arduboy_io_pkg::tim_tccr0a;
			arduboy_io_pkg::reg_tccr0b: tim_reg = arduboy_io_pkg::tim_tccr0b;
			arduboy_io_pkg::reg_tcnt0: tim_reg = arduboy_io_pkg::tim_tcnt0;
			arduboy_io_pkg::reg_ocr0a: tim_reg = arduboy_io_pkg::tim_ocr0a;
			arduboy_io_pkg::reg_ocr0b: tim_reg = arduboy_io_pkg::tim_ocr0b;
			arduboy_io_pkg::reg_timsk0: tim_reg = arduboy_io_pkg::tim_timsk0;
			arduboy_io_pkg::reg_tifr0: tim_reg = arduboy_io_pkg::tim_tifr0;
			default:
			begin
				tim_reg = arduboy_io_pkg::tim_tccr0a; // Don't care, no strobe
				is_tim = 1'b0;
			end
		endcase
	end

	assign pready = access;
	assign pslverr = access && (sel == arduboy_io_pkg::reg_none || (pwrite && is_pin));
	assign wr_en = access && pwrite && !pslverr; // Erroring writes are dropped
	assign wdata = pwdata;
	assign tim_wr = wr_en && is_tim;

	assign port_wr = {5{wr_en}} & {sel == arduboy_io_pkg::reg_portf,
		sel == arduboy_io_pkg::reg_porte, sel == arduboy_io_pkg::reg_portd,
		sel == arduboy_io_pkg::reg_portc, sel == arduboy_io_pkg::reg_portb};
	assign ddr_wr = {5{wr_en}} & {sel == arduboy_io_pkg::reg_ddrf,
		sel == arduboy_io_pkg::reg_ddre, sel == arduboy_io_pkg::reg_ddrd,
		sel == arduboy_io_pkg::reg_ddrc, sel == arduboy_io_pkg::reg_ddrb};

	always_comb
	begin
		case (sel)
			arduboy_io_pkg::reg_pinb: rd_mux = pin_q_b;
			arduboy_io_pkg::reg_ddrb: rd_mux = ddr_q_b;
			arduboy_io_pkg::reg_portb: rd_mux = port_q_b;
			arduboy_io_pkg::reg_pinc: rd_mux = pin_q_c;
			arduboy_io_pkg::reg_ddrc: rd_mux = ddr_q_c;
			arduboy_io_pkg::reg_portc: rd_mux = port_q_c;
			arduboy_io_pkg::reg_pind: rd_mux = pin_q_d;
			arduboy_io_pkg::reg_ddrd: rd_mux = ddr_q_d;
			arduboy_io_pkg::reg_portd: rd_mux = port_q_d;
			arduboy_io_pkg::reg_pine: rd_mux = pin_q_e;
			arduboy_io_pkg::reg_ddre: rd_mux = ddr_q_e;
			arduboy_io_pkg::reg_porte: rd_mux = port_q_e;
			arduboy_io_pkg::reg_pinf: rd_mux = pin_q_f;
			arduboy_io_pkg::reg_ddrf: rd_mux = ddr_q_f;
			arduboy_io_pkg::reg_portf: rd_mux = port_q_f;
			arduboy_io_pkg::reg_tifr0: rd_mux = tifr0_q;
			arduboy_io_pkg::reg_tccr0a: rd_mux = tccr0a_q;
			arduboy_io_pkg::reg_tccr0b: rd_mux = tccr0b_q;
			arduboy_io_pkg::reg_tcnt0: rd_mux = tcnt0_q;
			arduboy_io_pkg::reg_ocr0a: rd_mux = ocr0a_q;
			arduboy_io_pkg::reg_ocr0b: rd_mux = ocr0b_q;
			arduboy_io_pkg::reg_timsk0: rd_mux = timsk0_q;
			default: rd_mux = '0;
		endcase
	end

	assign prdata = (access && !pwrite) ? rd_mux : '0; // Quiet outside read access
endmodule

// File: rtl/gpio_port.sv
// One GPIO port with PORT and DDR registers, masked PIN read and direction-gated drive
`timescale 1ns/10ps
module gpio_port #(
	parameter logic [7:0] in_mask = 8'hff, // Bits wired to a real input
	parameter logic [7:0] invert_mask = 8'h00 // Active-low buttons
) (
	input  logic clk,
	input  logic rst,
	input  logic port_wr,
	input  logic ddr_wr,
	input  logic [arduboy_io_pkg::data_w-1:0] wdata,
	input  logic [arduboy_io_pkg::data_w-1:0] pin_in,
	output logic [arduboy_io_pkg::data_w-1:0] port_q,
	output logic [arduboy_io_pkg::data_w-1:0] ddr_q,
	output logic [arduboy_io_pkg::data_w-1:0] pin_q,
	output logic [arduboy_io_pkg::data_w-1:0] io_out
);
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			port_q <= '0;
			ddr_q <= '0; // All inputs out of reset
		end
		else
		begin
			if (port_wr)
				port_q <= wdata;
			if (ddr_wr)
				ddr_q <= wdata;
		end
	end

	// Unwired bits always read 0
	assign pin_q = (pin_in ^ invert_mask) & in_mask;

	// Pin drives only with its direction bit set
	assign io_out = port_q & ddr_q;
endmodule

// File: rtl/timer8_pwm.sv
// Timer 0 with shared prescaler, 8-bit counter, two compare units, PWM output and interrupt
`timescale 1ns/10ps
module timer8_pwm (
	input  logic clk,
	input  logic rst,
	input  logic tim_wr,
	input  arduboy_io_pkg::tim_reg_e tim_reg,
	input  logic [arduboy_io_pkg::data_w-1:0] wdata,
	output logic [arduboy_io_pkg::data_w-1:0] tccr0a_q, // COM0A 7:6, WGM 1:0
	output logic [arduboy_io_pkg::data_w-1:0] tccr0b_q, // Clock select 2:0
	output logic [arduboy_io_pkg::data_w-1:0] tcnt0_q,
	output logic [arduboy_io_pkg::data_w-1:0] ocr0a_q,
	output logic [arduboy_io_pkg::data_w-1:0] ocr0b_q,
	output logic [arduboy_io_pkg::data_w-1:0] timsk0_q,
	output logic [arduboy_io_pkg::data_w-1:0] tifr0_q,
	output logic oca,
	output logic oca_en,
	output logic irq
);
	logic [arduboy_io_pkg::prescale_w-1:0] presc;
	logic tick;
	logic fast_pwm;
	logic tov_ev;
	logic ocfa_ev;
	logic ocfb_ev;
	logic oca_tgl; // Normal-mode toggle output
	logic [arduboy_io_pkg::data_w-1:0] flag_set;
	logic [arduboy_io_pkg::data_w-1:0] flag_clr;

	// Free-running divider, no reset by writes
	always_ff @(posedge clk)
	begin
		if (rst)
			presc <= '0;
		else
			presc <= presc + 1'b1;
	end

	always_comb
	begin
		case (arduboy_io_pkg::clk_sel_e'(tccr0b_q[2:0]))
			arduboy_io_pkg::cs_div1: tick = 1'b1;
			arduboy_io_pkg::cs_div8: tick = &presc[2:0];
			arduboy_io_pkg::cs_div64: tick = &presc[5:0];
			arduboy_io_pkg::cs_div256: tick = &presc[7:0];
			arduboy_io_pkg::cs_div1024: tick = &presc;
			default: tick = 1'b0; // Stopped, codes 6 and 7 too
		endcase
	end

	assign fast_pwm = arduboy_io_pkg::wgm_e'(tccr0a_q[1:0]) == arduboy_io_pkg::wgm_fast_pwm;

	// Events qualify with the tick so a stopped counter fires nothing
	assign tov_ev = tick && (&tcnt0_q); // FF to 00 wrap
	assign ocfa_ev = tick && (tcnt0_q == ocr0a_q);
	assign ocfb_ev = tick && (tcnt0_q == ocr0b_q);

	always_comb
	begin
		flag_set = '0;
		flag_set[arduboy_io_pkg::tov_bit] = tov_ev;
		flag_set[arduboy_io_pkg::ocfa_bit] = ocfa_ev;
		flag_set[arduboy_io_pkg::ocfb_bit] = ocfb_ev;
	end

	// Write 1 to clear
	assign flag_clr = (tim_wr && tim_reg == arduboy_io_pkg::tim_tifr0) ? wdata : '0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tccr0a_q <= '0;
			tccr0b_q <= '0;
			tcnt0_q <= '0;
			ocr0a_q <= '0;
			ocr0b_q <= '0;
			timsk0_q <= '0;
			tifr0_q <= '0;
			oca_tgl <= 1'b0;
		end
		else
		begin
			if (tick)
				tcnt0_q <= tcnt0_q + 1'b1; // Wraps in both modes
			if (tim_wr)
			begin
				case (tim_reg)
					arduboy_io_pkg::tim_tccr0a: tccr0a_q <= wdata;
					arduboy_io_pkg::tim_tccr0b: tccr0b_q <= wdata;
					arduboy_io_pkg::tim_tcnt0: tcnt0_q <= wdata; // Load beats the tick
					arduboy_io_pkg::tim_ocr0a: ocr0a_q <= wdata;
					arduboy_io_pkg::tim_ocr0b: ocr0b_q <= wdata;
					arduboy_io_pkg::tim_timsk0: timsk0_q <= wdata;
					default: ; // TIFR0 goes through flag_clr
				endcase
			end
			tifr0_q <= (tifr0_q & ~flag_clr) | flag_set; // Set wins over clear
			if (ocfa_ev && !fast_pwm)
				oca_tgl <= ~oca_tgl;
		end
	end

	// Fast PWM high below the compare value, one count per tick
	assign oca = fast_pwm ? (tcnt0_q < ocr0a_q) : oca_tgl;
	assign oca_en = |tccr0a_q[7:6]; // Any COM0A mode takes the pin
	assign irq = |(tifr0_q & timsk0_q);
endmodule

// File: rtl/board_pin_map.sv
// Arduboy board wiring: button sync and routing to ports, LED, buzzer and OLED pin drive
`timescale 1ns/10ps
module board_pin_map (
	input  logic clk,
	input  logic rst,
	input  logic [5:0] buttons, // Right, left, down, up, A, B from bit 0
	input  logic [arduboy_io_pkg::data_w-1:0] pb_out,
	input  logic [arduboy_io_pkg::data_w-1:0] pc_out,
	input  logic [arduboy_io_pkg::data_w-1:0] pd_out,
	input  logic oca,
	input  logic oca_en,
	output logic [arduboy_io_pkg::data_w-1:0] pb_in,
	output logic [arduboy_io_pkg::data_w-1:0] pe_in,
	output logic [arduboy_io_pkg::data_w-1:0] pf_in,
	output logic [2:0] rgb,
	output logic [1:0] buzzer,
	output logic oled_dc,
	output logic oled_cs,
	output logic oled_rst
);
	logic [5:0] btn_meta; // First stage, may go metastable
	logic [5:0] btn_sync;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			btn_meta <= '0;
			btn_sync <= '0;
		end
		else
		begin
			btn_meta <= buttons;
			btn_sync <= btn_meta;
		end
	end

	assign pb_in = {3'b000, btn_sync[5], 4'b0000}; // B on PB4
	assign pe_in = {1'b0, btn_sync[4], 6'b000000}; // A on PE6
	// Up PF7, right PF6, left PF5, down PF4
	assign pf_in = {btn_sync[3], btn_sync[0], btn_sync[1], btn_sync[2], 4'b0000};

	// Common anode LED, so PWM is inverted to keep duty as brightness
	assign rgb[0] = pb_out[5];
	assign rgb[1] = oca_en ? ~oca : pb_out[7];
	assign rgb[2] = pb_out[6];

	assign buzzer = pc_out[7:6];
	assign oled_dc = pd_out[4];
	assign oled_cs = pd_out[6];
	assign oled_rst = pd_out[7];
endmodule

// File: rtl/arduboy_io_top.sv
// Arduboy I/O subsystem top: APB control, five GPIO ports, timer 0 and board pin map
`timescale 1ns/10ps
module arduboy_io_top (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [arduboy_io_pkg::addr_w-1:0] paddr,
	input  logic [arduboy_io_pkg::data_w-1:0] pwdata,
	output logic [arduboy_io_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic [5:0] buttons,
	output logic [2:0] rgb,
	output logic [1:0] buzzer,
	output logic oled_dc,
	output logic oled_cs,
	output logic oled_rst,
	output logic irq // Timer 0 request
);
	logic [4:0] port_wr;
	logic [4:0] ddr_wr;
	logic tim_wr;
	arduboy_io_pkg::tim_reg_e tim_reg;
	logic [arduboy_io_pkg::data_w-1:0] wdata;
	logic [arduboy_io_pkg::data_w-1:0] port_q_b, port_q_c, port_q_d, port_q_e, port_q_f;
	logic [arduboy_io_pkg::data_w-1:0] ddr_q_b, ddr_q_c, ddr_q_d, ddr_q_e, ddr_q_f;
	logic [arduboy_io_pkg::data_w-1:0] pin_q_b, pin_q_c, pin_q_d, pin_q_e, pin_q_f;
	logic [arduboy_io_pkg::data_w-1:0] tccr0a_q, tccr0b_q, tcnt0_q, ocr0a_q;
	logic [arduboy_io_pkg::data_w-1:0] ocr0b_q, timsk0_q, tifr0_q;
	logic oca;
	logic oca_en;
	logic [arduboy_io_pkg::data_w-1:0] pb_in, pe_in, pf_in; // Routed buttons
	logic [arduboy_io_pkg::data_w-1:0] pb_out, pc_out, pd_out; // Board-facing drive

	// Names line up one to one with the wires above
	apb_io_ctrl apb_io_ctrl_inst (.*);

	timer8_pwm timer8_pwm_inst (.*);

	board_pin_map board_pin_map_inst (.*);

	// Port B: B button inverted, LED on 7:5
	gpio_port #(.in_mask(8'hf0), .invert_mask(8'h10)) gpio_b_inst (
		.clk, .rst, .port_wr(port_wr[0]), .ddr_wr(ddr_wr[0]), .wdata, .pin_in(pb_in),
		.port_q(port_q_b), .ddr_q(ddr_q_b), .pin_q(pin_q_b), .io_out(pb_out)
	);

	// Port C: buzzer only, nothing to read back
	gpio_port #(.in_mask(8'hc0), .invert_mask(8'h00)) gpio_c_inst (
		.clk, .rst, .port_wr(port_wr[1]), .ddr_wr(ddr_wr[1]), .wdata, .pin_in('0),
		.port_q(port_q_c), .ddr_q(ddr_q_c), .pin_q(pin_q_c), .io_out(pc_out)
	);

	// Port D: OLED control
	gpio_port #(.in_mask(8'hd0), .invert_mask(8'h00)) gpio_d_inst (
		.clk, .rst, .port_wr(port_wr[2]), .ddr_wr(ddr_wr[2]), .wdata, .pin_in('0),
		.port_q(port_q_d), .ddr_q(ddr_q_d), .pin_q(pin_q_d), .io_out(pd_out)
	);

	// Port E: A button, no board outputs
	gpio_port #(.in_mask(8'h40), .invert_mask(8'h40)) gpio_e_inst (
		.clk, .rst, .port_wr(port_wr[3]), .ddr_wr(ddr_wr[3]), .wdata, .pin_in(pe_in),
		.port_q(port_q_e), .ddr_q(ddr_q_e), .pin_q(pin_q_e), .io_out()
	);

	// Port F: D-pad on 7:4
	gpio_port #(.in_mask(8'hf3), .invert_mask(8'hf0)) gpio_f_inst (
		.clk, .rst, .port_wr(port_wr[4]), .ddr_wr(ddr_wr[4]), .wdata, .pin_in(pf_in),
		.port_q(port_q_f), .ddr_q(ddr_q_f), .pin_q(pin_q_f), .io_out()
	);
endmodule

// File: tb/arduboy_io_props.sv
// Bound checks on the APB handshake, timer interrupt and reset state of the I/O top
`timescale 1ns/10ps
module arduboy_io_props (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic pready,
	input  logic pslverr,
	input  logic irq,
	input  logic tim_wr,
	input  logic [7:0] tcnt0_q,
	input  logic [7:0] ocr0a_q,
	input  logic [7:0] ocr0b_q
);
	int prop_fails = 0; // Failed assertion count

	// Access cycle only and straight after a setup cycle
	property p_pready_access;
		@(posedge clk) disable iff (rst)
			pready |-> psel && penable && $past(psel && !penable);
	endproperty

	// Error only with pready on a map hole or a PIN write
	property p_slverr_with_ready;
		@(posedge clk) disable iff (rst)
			pslverr |-> pready
				&& (!(paddr inside {[8'h23:8'h31], 8'h35, [8'h44:8'h48], 8'h6e})
				|| (pwrite && paddr inside {8'h23, 8'h26, 8'h29, 8'h2c, 8'h2f}));
	endproperty

	// New request only after a counter wrap, a compare match or a timer write
	property p_irq_source;
		@(posedge clk) disable iff (rst)
			$rose(irq) |-> $past(tim_wr || (&tcnt0_q) || tcnt0_q == ocr0a_q
				|| tcnt0_q == ocr0b_q);
	endproperty

	// First cycle out of reset is quiet
	property p_reset_quiet;
		@(posedge clk) $past(rst) |-> !pready && !irq;
	endproperty

	a_pready_access: assert property (p_pready_access)
	else
	begin
		$error("pready high outside an APB access cycle");
		prop_fails++;
	end

	a_slverr_with_ready: assert property (p_slverr_with_ready)
	else
	begin
		$error("pslverr without pready or on a mapped register");
		prop_fails++;
	end

	a_irq_source: assert property (p_irq_source)
	else
	begin
		$error("irq rose without a timer event or register write");
		prop_fails++;
	end

	a_reset_quiet: assert property (p_reset_quiet)
	else
	begin
		$error("pready or irq high in the cycle after reset");
		prop_fails++;
	end
endmodule

bind arduboy_io_top arduboy_io_props arduboy_io_props_inst (.*);

// File: tb/tb_arduboy_io.sv
// Testbench for the Arduboy I/O top: registers, buttons, board pins, timer IRQ and PWM
`timescale 1ns/10ps
module tb_arduboy_io;
	localparam int max_cycles = 4000; // Tests need about 1500

	logic clk = 1'b0;
	logic rst;
	logic psel, penable, pwrite;
	logic [7:0] paddr, pwdata, prdata;
	logic pready, pslverr;
	logic [5:0] buttons; // Right, left, down, up, A, B from bit 0
	logic [2:0] rgb;
	logic [1:0] buzzer;
	logic oled_dc, oled_cs, oled_rst, irq;

	logic [31:0] lfsr = 32'h9c48;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int err_mark = 0; // Errors before the running test
	int tests = 0;

	arduboy_io_top arduboy_io_top_inst (.*);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic void check_byte(input logic [7:0] got, input logic [7:0] exp,
		input string what);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endfunction

	// Setup then access with the result sampled mid access cycle
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [7:0] data,
		output logic [7:0] rdata, output logic err);
		int n;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		n = 0;
		while (!pready && n < 8)
		begin
			@(negedge clk);
			n++;
		end
		if (!pready)
		begin
			$display("APB transfer to address %h never got pready", addr);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk); // Write lands on this edge
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data, output logic err);
		logic [7:0] rd_dummy;
		apb_xfer(1'b1, addr, data, rd_dummy, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [7:0] data, output logic err);
		apb_xfer(1'b0, addr, 8'h00, data, err);
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == err_mark)
			$display("Test %0d %s: ok", tests, name);
		else
			$display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial
	begin
		logic [7:0] rd;
		logic [7:0] wv;
		logic [7:0] pv;
		logic [7:0] dv;
		logic [7:0] drive;
		logic [5:0] btn;
		logic err;
		int low_cnt;
		int n;

		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 8'h00;
		buttons = 6'd0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// DDR and PORT are the 2nd and 3rd byte of each port group
		for (int a = 8'h23; a <= 8'h48; a++)
		begin
			if ((a <= arduboy_io_pkg::portf_addr && (a - arduboy_io_pkg::pinb_addr) % 3 != 0)
				|| a == arduboy_io_pkg::ocr0a_addr || a == arduboy_io_pkg::ocr0b_addr)
			begin
				wv = rand_bits(8);
				apb_write(a[7:0], wv, err);
				check_byte({7'd0, err}, 8'd0, "pslverr on mapped write");
				apb_read(a[7:0], rd, err);
				check_byte(rd, wv, $sformatf("register %h", a[7:0]));
			end
		end
		apb_read(8'h50, rd, err); // Hole in the map
		check_byte({7'd0, err}, 8'd1, "pslverr on unmapped read");
		apb_write(arduboy_io_pkg::pinb_addr, 8'hff, err);
		check_byte({7'd0, err}, 8'd1, "pslverr on PINB write");
		report_test("register access");

		repeat (8)
		begin
			wv = rand_bits(6);
			btn = wv[5:0];
			@(posedge clk);
			buttons <= btn;
			repeat (4) @(posedge clk);
			// Routed buttons read back inverted
			apb_read(arduboy_io_pkg::pinb_addr, rd, err);
			check_byte(rd, {3'b000, ~btn[5], 4'h0}, "PINB");
			apb_read(arduboy_io_pkg::pine_addr, rd, err);
			check_byte(rd, {1'b0, ~btn[4], 6'h00}, "PINE");
			apb_read(arduboy_io_pkg::pinf_addr, rd, err);
			check_byte(rd, {~btn[3], ~btn[0], ~btn[1], ~btn[2], 4'h0}, "PINF"); // Up to down
		end
		report_test("button routing");

		repeat (4)
		begin
			pv = rand_bits(8);
			dv = rand_bits(8);
			drive = pv & dv; // Pin drives only where DDR is set
			apb_write(arduboy_io_pkg::portd_addr, pv, err);
			apb_write(arduboy_io_pkg::ddrd_addr, dv, err);
			apb_write(arduboy_io_pkg::portc_addr, pv, err);
			apb_write(arduboy_io_pkg::ddrc_addr, dv, err);
			apb_write(arduboy_io_pkg::portb_addr, pv, err);
			apb_write(arduboy_io_pkg::ddrb_addr, dv, err);
			@(negedge clk);
			check_byte({5'd0, oled_rst, oled_cs, oled_dc},
				{5'd0, drive[7], drive[6], drive[4]}, "OLED pins");
			check_byte({6'd0, buzzer}, {6'd0, drive[7:6]}, "buzzer pins");
			check_byte({5'd0, rgb}, {5'd0, drive[6], drive[7], drive[5]}, "RGB pins");
		end
		report_test("board pins");

		apb_write(arduboy_io_pkg::tccr0a_addr, 8'h00, err); // Normal mode
		apb_write(arduboy_io_pkg::timsk0_addr, 8'h01, err); // TOV only
		apb_write(arduboy_io_pkg::tccr0b_addr, 8'h01, err); // div1
		apb_write(arduboy_io_pkg::tcnt0_addr, 8'h00, err);
		apb_write(arduboy_io_pkg::tifr0_addr, 8'h07, err); // Drop stale flags
		n = 0;
		while (!irq && n < 257) // 260 counted from the TCNT0 load
		begin
			@(negedge clk);
			n++;
		end
		assert (irq)
		else
		begin
			$display("Timer overflow irq did not rise within 260 cycles");
			errors++;
		end
		apb_read(arduboy_io_pkg::tifr0_addr, rd, err);
		check_byte(rd & 8'h01, 8'h01, "TIFR0 TOV bit");
		apb_write(arduboy_io_pkg::tifr0_addr, 8'h01, err);
		@(negedge clk);
		check_byte({7'd0, irq}, 8'd0, "irq after TOV clear");
		report_test("overflow interrupt");

		wv = rand_bits(8);
		apb_write(arduboy_io_pkg::ocr0a_addr, wv, err);
		apb_write(arduboy_io_pkg::tccr0a_addr, 8'h83, err); // COM0A 10 in fast PWM
		low_cnt = 0;
		repeat (256) // One full counter period
		begin
			@(negedge clk);
			if (!rgb[1])
				low_cnt++;
		end
		checks++;
		assert (low_cnt == wv)
		else
		begin
			$display("Fail %0t: rgb[1] low %0d of 256 cycles, expected %0d", $time, low_cnt, wv);
			errors++;
		end
		report_test("fast PWM duty");

		apb_write(arduboy_io_pkg::tccr0b_addr, 8'h02, err); // div8
		apb_read(arduboy_io_pkg::tcnt0_addr, pv, err);
		repeat (77) @(posedge clk); // Samples land 80 cycles apart
		apb_read(arduboy_io_pkg::tcnt0_addr, dv, err);
		wv = dv - pv; // Modulo 256
		checks++;
		assert (wv == 8'd10 || wv == 8'd11)
		else
		begin
			$display("Fail %0t: TCNT0 moved %0d in 80 cycles at div8, expected 10 or 11",
				$time, wv);
			errors++;
		end
		report_test("prescaler div8");

		$display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d", tests,
			checks, errors, arduboy_io_top_inst.arduboy_io_props_inst.prop_fails);
		if (errors == 0 && arduboy_io_top_inst.arduboy_io_props_inst.prop_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule

// File: sources.f
rtl/arduboy_io_pkg.sv
rtl/apb_io_ctrl.sv
rtl/gpio_port.sv
rtl/timer8_pwm.sv
rtl/board_pin_map.sv
rtl/arduboy_io_top.sv
tb/arduboy_io_props.sv
tb/tb_arduboy_io.sv
